// File: design/data_mem.sv
/* Local data RAM with an AGU-addressed write port and a registered read stream. */

`include "mpu_params.svh"

`default_nettype none

module data_mem
	import mpu_pkg::*;
(
	input  wire        clock,
	input  wire        agu_free,
	input  mpu_addr_t  agu_addr,
	input  wire        agu_valid,
	input  wire        mem_wr,
	input  mpu_word_t  mem_wdata,
	output logic       rd_valid,
	output mpu_word_t  rd_data
);

	mpu_word_t ram [`MPU_DATA_DEPTH];
	logic      wr_en;
	logic      rd_en;

	// a valid address reads while free-running and writes otherwise.
	assign wr_en = agu_valid && mem_wr && !agu_free;
	assign rd_en = agu_valid && agu_free;

	always_ff @(posedge clock) begin
		if (wr_en) begin
			ram[agu_addr] <= mem_wdata;
		end
	end

	// a read address returns its word and its flag one cycle later.
	always_ff @(posedge clock) begin
		rd_valid <= rd_en;
	end

	always_ff @(posedge clock) begin
		if (rd_en) begin
			rd_data <= ram[agu_addr];
		end
	end

endmodule

`default_nettype wire

// File: design/host_cmd_fsm.sv
/* Host word decoder: captures command fields and starts the AGU, the data
   memory writes and the thread dispatcher. */

`include "mpu_params.svh"

`default_nettype none

module host_cmd_fsm
	import mpu_pkg::*;
(
	input  wire         clock,
	input  wire         reset,
	input  wire         host_req,
	input  mpu_word_t   host_data,
	input  wire         agu_done,
	input  wire         run_done,
	output logic        busy,
	output logic        stopped,
	output logic        agu_start,
	output logic        agu_free,
	output logic        agu_step,
	output mpu_dcount_t agu_count,
	output mpu_addr_t   agu_stride,
	output mpu_addr_t   agu_base,
	output logic        mem_wr,
	output mpu_word_t   mem_wdata,
	output logic        prog_wr,
	output mpu_thread_t prog_thread,
	output mpu_pidx_t   prog_index,
	output mpu_word_t   prog_wdata,
	output logic        len_wr,
	output logic        run_start,
	output mpu_thread_t run_thread
);

	cmd_state_e  state;
	mpu_cmd_t    cmd_word;
	mpu_plen_t   plen;
	mpu_dcount_t remain;
	mpu_pidx_t   widx;
	logic        wr_pulse;

	assign cmd_word = host_data;

	// program counts above the slot size are clipped.
	assign plen = (host_data[`MPU_PLEN_W-1:0] > `MPU_PROG_LEN) ?
		`MPU_PLEN_W'(`MPU_PROG_LEN) : host_data[`MPU_PLEN_W-1:0];

	// a store data word writes and steps the AGU in the same cycle.
	assign mem_wr   = wr_pulse;
	assign agu_step = wr_pulse;

	assign busy    = (state == RUN_WAIT) || (state == LD_WAIT);
	assign stopped = (state == STOPPED);

	// ##########################################################
	// decoder state and strobes.
	always_ff @(posedge clock) begin
		if (reset) begin
			state     <= IDLE;
			agu_start <= 1'b0;
			agu_free  <= 1'b0;
			wr_pulse  <= 1'b0;
			prog_wr   <= 1'b0;
			len_wr    <= 1'b0;
			run_start <= 1'b0;
			remain    <= '0;
		end else begin
			agu_start <= 1'b0;
			wr_pulse  <= 1'b0;
			prog_wr   <= 1'b0;
			len_wr    <= 1'b0;
			run_start <= 1'b0;
			case (state)
				IDLE: begin
					if (host_req) begin
						case (cmd_word.opcode)
							OP_STOP:       state <= STOPPED;
							OP_RUN:        state <= RUN_ID;
							OP_STORE_PROG: state <= PROG_ID;
							OP_STORE_DATA: state <= ST_COUNT;
							OP_LOAD_DATA:  state <= LD_COUNT;
							default:       state <= IDLE;
						endcase
					end
				end
				STOPPED: begin
					if (host_req && cmd_word.opcode == OP_START) begin
						state <= IDLE;
					end
				end
				RUN_ID: begin
					if (host_req) begin
						run_start <= 1'b1;
						state     <= RUN_WAIT;
					end
				end
				RUN_WAIT: begin
					if (run_done) begin
						state <= IDLE;
					end
				end
				PROG_ID: begin
					if (host_req) begin
						state <= PROG_COUNT;
					end
				end
				PROG_COUNT: begin
					if (host_req) begin
						if (plen == '0) begin
							state <= IDLE;
						end else begin
							len_wr <= 1'b1;
							remain <= mpu_dcount_t'(plen);
							state  <= PROG_WORDS;
						end
					end
				end
				PROG_WORDS: begin
					if (host_req) begin
						prog_wr <= 1'b1;
						remain  <= remain - 1'b1;
						if (remain == 1) begin
							state <= IDLE;
						end
					end
				end
				ST_COUNT, LD_COUNT: begin
					if (host_req) begin
						state <= (state == ST_COUNT) ? ST_STRIDE : LD_STRIDE;
					end
				end
				ST_STRIDE, LD_STRIDE: begin
					if (host_req) begin
						state <= (state == ST_STRIDE) ? ST_BASE : LD_BASE;
					end
				end
				ST_BASE, LD_BASE: begin
					if (host_req) begin
						if (agu_count == '0) begin
							state <= IDLE;
						end else begin
							agu_start <= 1'b1;
							agu_free  <= (state == LD_BASE);
							remain    <= agu_count;
							state     <= (state == ST_BASE) ? ST_WORDS : LD_WAIT;
						end
					end
				end
				ST_WORDS: begin
					if (host_req) begin
						wr_pulse <= 1'b1;
						remain   <= remain - 1'b1;
						if (remain == 1) begin
							state <= IDLE;
						end
					end
				end
				LD_WAIT: begin
					if (agu_done) begin
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// ##########################################################
	// captured fields and write payloads.
	always_ff @(posedge clock) begin
		if (host_req) begin
			case (state)
				RUN_ID:              run_thread  <= host_data[`MPU_THREAD_W-1:0];
				PROG_ID:             prog_thread <= host_data[`MPU_THREAD_W-1:0];
				ST_COUNT, LD_COUNT:  agu_count   <= host_data[`MPU_DATA_AW:0];
				ST_STRIDE, LD_STRIDE: agu_stride <= host_data[`MPU_DATA_AW-1:0];
				ST_BASE, LD_BASE:    agu_base    <= host_data[`MPU_DATA_AW-1:0];
				ST_WORDS:            mem_wdata   <= host_data;
				default: ;
			endcase
		end
		if (host_req && state == PROG_COUNT) begin
			// the slot length travels on the program data lines.
			prog_wdata <= mpu_word_t'(plen);
			widx       <= '0;
		end else if (host_req && state == PROG_WORDS) begin
			prog_wdata <= host_data;
			prog_index <= widx;
			widx       <= widx + 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: design/mpu_host_top.sv
/* Host command port top level: decoder, AGU, data memory and dispatcher. */

`include "mpu_params.svh"

`default_nettype none

module mpu_host_top
	import mpu_pkg::*;
(
	input  wire       clock,
	input  wire       reset,
	input  wire       host_req,
	input  mpu_word_t host_data,
	output logic      busy,
	output logic      stopped,
	output logic      instr_valid,
	output mpu_word_t instr,
	output logic      rd_valid,
	output mpu_word_t rd_data
);

	logic        agu_start;
	logic        agu_free;
	logic        agu_step;
	mpu_dcount_t agu_count;
	mpu_addr_t   agu_stride;
	mpu_addr_t   agu_base;
	mpu_addr_t   agu_addr;
	logic        agu_valid;
	logic        agu_done;
	logic        mem_wr;
	mpu_word_t   mem_wdata;
	logic        prog_wr;
	mpu_thread_t prog_thread;
	mpu_pidx_t   prog_index;
	mpu_word_t   prog_wdata;
	logic        len_wr;
	logic        run_start;
	mpu_thread_t run_thread;
	logic        run_done;

	host_cmd_fsm u_host_cmd_fsm (
		.clock       (clock),
		.reset       (reset),
		.host_req    (host_req),
		.host_data   (host_data),
		.agu_done    (agu_done),
		.run_done    (run_done),
		.busy        (busy),
		.stopped     (stopped),
		.agu_start   (agu_start),
		.agu_free    (agu_free),
		.agu_step    (agu_step),
		.agu_count   (agu_count),
		.agu_stride  (agu_stride),
		.agu_base    (agu_base),
		.mem_wr      (mem_wr),
		.mem_wdata   (mem_wdata),
		.prog_wr     (prog_wr),
		.prog_thread (prog_thread),
		.prog_index  (prog_index),
		.prog_wdata  (prog_wdata),
		.len_wr      (len_wr),
		.run_start   (run_start),
		.run_thread  (run_thread)
	);

	strided_agu u_strided_agu (
		.clock      (clock),
		.reset      (reset),
		.agu_start  (agu_start),
		.agu_free   (agu_free),
		.agu_step   (agu_step),
		.agu_count  (agu_count),
		.agu_stride (agu_stride),
		.agu_base   (agu_base),
		.agu_addr   (agu_addr),
		.agu_valid  (agu_valid),
		.agu_done   (agu_done)
	);

	data_mem u_data_mem (
		.clock     (clock),
		.agu_free  (agu_free),
		.agu_addr  (agu_addr),
		.agu_valid (agu_valid),
		.mem_wr    (mem_wr),
		.mem_wdata (mem_wdata),
		.rd_valid  (rd_valid),
		.rd_data   (rd_data)
	);

	thread_dispatch u_thread_dispatch (
		.clock       (clock),
		.reset       (reset),
		.prog_wr     (prog_wr),
		.prog_thread (prog_thread),
		.prog_index  (prog_index),
		.prog_wdata  (prog_wdata),
		.len_wr      (len_wr),
		.run_start   (run_start),
		.run_thread  (run_thread),
		.instr_valid (instr_valid),
		.instr       (instr),
		.run_done    (run_done)
	);

endmodule

`default_nettype wire

// File: design/mpu_params.svh
/* Widths, depths and derived field widths of the host command port. */

`ifndef MPU_PARAMS_SVH
`define MPU_PARAMS_SVH

`default_nettype none

// host, data and instruction words share one width.
`define MPU_WORD_W      32
`define MPU_OP_W        3

// local data memory.
`define MPU_DATA_AW     8
`define MPU_DATA_DEPTH  256

// one program slot per thread.
`define MPU_THREADS     4
`define MPU_THREAD_W    2
`define MPU_PROG_LEN    16
`define MPU_PIDX_W      4
`define MPU_PLEN_W      5

`default_nettype wire

`endif

// File: design/mpu_pkg.sv
/* Opcode and decoder state enums, word types and the command word layout. */

`include "mpu_params.svh"

`default_nettype none

package mpu_pkg;

	// ##########################################################
	// command encoding.
	typedef enum logic [`MPU_OP_W-1:0] {
		OP_STOP       = 3'd0,
		OP_START      = 3'd1,
		OP_RUN        = 3'd2,
		OP_STORE_PROG = 3'd3,
		OP_STORE_DATA = 3'd4,
		OP_LOAD_DATA  = 3'd5
	} mpu_opcode_e;

	// the opcode occupies the top bits of the first word of a sequence.
	typedef struct packed {
		mpu_opcode_e                          opcode;
		logic [`MPU_WORD_W-`MPU_OP_W-1:0]     arg;
	} mpu_cmd_t;

	// ##########################################################
	// decoder states.
	typedef enum logic [3:0] {
		IDLE, STOPPED,
		RUN_ID, RUN_WAIT,
		PROG_ID, PROG_COUNT, PROG_WORDS,
		ST_COUNT, ST_STRIDE, ST_BASE, ST_WORDS,
		LD_COUNT, LD_STRIDE, LD_BASE, LD_WAIT
	} cmd_state_e;

	typedef logic [`MPU_WORD_W-1:0]   mpu_word_t;
	typedef logic [`MPU_DATA_AW-1:0]  mpu_addr_t;
	typedef logic [`MPU_DATA_AW:0]    mpu_dcount_t;
	typedef logic [`MPU_THREAD_W-1:0] mpu_thread_t;
	typedef logic [`MPU_PIDX_W-1:0]   mpu_pidx_t;
	typedef logic [`MPU_PLEN_W-1:0]   mpu_plen_t;

endpackage

`default_nettype wire

// File: design/strided_agu.sv
/* Strided address generator, free-running for loads and stepped for stores. */

`include "mpu_params.svh"

`default_nettype none

module strided_agu
	import mpu_pkg::*;
(
	input  wire         clock,
	input  wire         reset,
	input  wire         agu_start,
	input  wire         agu_free,
	input  wire         agu_step,
	input  mpu_dcount_t agu_count,
	input  mpu_addr_t   agu_stride,
	input  mpu_addr_t   agu_base,
	output mpu_addr_t   agu_addr,
	output logic        agu_valid,
	output logic        agu_done
);

	mpu_addr_t   stride_q;
	mpu_dcount_t left;
	logic        advance;

	assign advance = agu_valid && (agu_free || agu_step);

	always_ff @(posedge clock) begin
		if (reset) begin
			agu_valid <= 1'b0;
			agu_done  <= 1'b0;
			left      <= '0;
		end else begin
			agu_done <= 1'b0;
			if (agu_start) begin
				left      <= agu_count;
				agu_valid <= (agu_count != '0);
				agu_done  <= (agu_count == '0);
			end else if (advance) begin
				left <= left - 1'b1;
				if (left == 1) begin
					agu_valid <= 1'b0;
					agu_done  <= 1'b1;
				end
			end
		end
	end

	// the address wraps around the data memory.
	always_ff @(posedge clock) begin
		if (agu_start) begin
			agu_addr <= agu_base;
			stride_q <= agu_stride;
		end else if (advance) begin
			agu_addr <= agu_addr + stride_q;
		end
	end

endmodule

`default_nettype wire

// File: design/thread_dispatch.sv
/* Per-thread program slots, length table and the instruction streamer. */

`include "mpu_params.svh"

`default_nettype none

module thread_dispatch
	import mpu_pkg::*;
(
	input  wire         clock,
	input  wire         reset,
	input  wire         prog_wr,
	input  mpu_thread_t prog_thread,
	input  mpu_pidx_t   prog_index,
	input  mpu_word_t   prog_wdata,
	input  wire         len_wr,
	input  wire         run_start,
	input  mpu_thread_t run_thread,
	output logic        instr_valid,
	output mpu_word_t   instr,
	output logic        run_done
);

	mpu_word_t   prog_ram [`MPU_THREADS*`MPU_PROG_LEN];
	mpu_plen_t   len_tab [`MPU_THREADS];
	mpu_plen_t   start_len;
	mpu_thread_t cur_thread;
	mpu_pidx_t   cur_idx;
	mpu_plen_t   cur_len;
	logic        active;
	logic        last_idx;

	assign start_len = len_tab[run_thread];
	assign last_idx  = ({1'b0, cur_idx} == cur_len - 1'b1);

	// ##########################################################
	// program storage.
	always_ff @(posedge clock) begin
		if (prog_wr) begin
			prog_ram[{prog_thread, prog_index}] <= prog_wdata;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int t = 0; t < `MPU_THREADS; t++) begin
				len_tab[t] <= '0;
			end
		end else if (len_wr) begin
			len_tab[prog_thread] <= prog_wdata[`MPU_PLEN_W-1:0];
		end
	end

	// ##########################################################
	// instructions stream out one per cycle.
	always_ff @(posedge clock) begin
		if (reset) begin
			active      <= 1'b0;
			instr_valid <= 1'b0;
			run_done    <= 1'b0;
		end else begin
			instr_valid <= active;
			run_done    <= 1'b0;
			if (run_start) begin
				active   <= (start_len != '0);
				run_done <= (start_len == '0);
			end else if (active && last_idx) begin
				active   <= 1'b0;
				run_done <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (run_start) begin
			cur_thread <= run_thread;
			cur_len    <= start_len;
			cur_idx    <= '0;
		end else if (active) begin
			instr   <= prog_ram[{cur_thread, cur_idx}];
			cur_idx <= cur_idx + 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Builds the Verilator model of the host command port and runs it.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal -f sources.f \
	--top-module mpu_host_tb -o mpu_host_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "build failed"
	exit 1
fi

./obj_dir/mpu_host_sim +verilator+error+limit+100 > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
fi

if grep -q "^TEST OK$" sim.log; then
	exit 0
fi
exit 1

// File: sources.f
+incdir+design
design/mpu_pkg.sv
design/host_cmd_fsm.sv
design/strided_agu.sv
design/data_mem.sv
design/thread_dispatch.sv
design/mpu_host_top.sv
test/mpu_host_chk.sv
test/mpu_host_tb.sv

// File: test/mpu_host_chk.sv
/* Bound checker with shadow program and data memories, an expected output
   stream and concurrent assertions on the host port outputs. */

`include "mpu_params.svh"

`default_nettype none

module mpu_host_chk
	import mpu_pkg::*;
(
	input wire       clock,
	input wire       reset,
	input wire       host_req,
	input mpu_word_t host_data,
	input wire       busy,
	input wire       stopped,
	input wire       instr_valid,
	input mpu_word_t instr,
	input wire       rd_valid,
	input mpu_word_t rd_data
);

	timeunit 1ns;
	timeprecision 1ps;

	cmd_state_e  state;
	mpu_word_t   data_shadow [`MPU_DATA_DEPTH];
	logic        data_known [`MPU_DATA_DEPTH];
	mpu_word_t   prog_shadow [`MPU_THREADS][`MPU_PROG_LEN];
	logic [4:0]  len_shadow [`MPU_THREADS];
	logic [1:0]  thr;
	logic [4:0]  plen_q;
	logic [4:0]  pidx;
	logic [8:0]  cnt;
	logic [8:0]  left;
	logic [7:0]  stride;
	logic [7:0]  addr;
	logic [4:0]  req_len;

	// read data and instructions share one expected stream.
	mpu_word_t   exp_word [512];
	logic        exp_known [512];
	logic [8:0]  head;
	logic [8:0]  total;
	logic [1:0]  lead;
	logic        stream_on;
	logic        stream_load;
	logic        exp_busy;
	logic        out_now;
	logic        exp_rd_valid;
	logic        exp_instr_valid;
	mpu_word_t   exp_head;
	logic        exp_head_known;

	logic        fail_flag;
	string       fail_name;
	mpu_word_t   fail_got;
	mpu_word_t   fail_exp;

	assign out_now         = stream_on && (lead == 0) && (head != total);
	assign exp_rd_valid    = out_now && stream_load;
	assign exp_instr_valid = out_now && !stream_load;
	assign exp_head        = exp_word[head];
	assign exp_head_known  = exp_known[head];
	assign req_len = (host_data[4:0] > 5'd16) ? 5'd16 : host_data[4:0];

	function automatic void note_failure(input string name, input mpu_word_t got,
			input mpu_word_t exp);
		if (!fail_flag) begin
			fail_flag = 1'b1;
			fail_name = name;
			fail_got  = got;
			fail_exp  = exp;
		end
	endfunction

	initial fail_flag = 1'b0;

	// ############################################################
	// the shadow decoder follows the command sequences word by word.
	always_ff @(posedge clock) begin
		mpu_addr_t rd_addr;
		if (reset) begin
			state     <= IDLE;
			stream_on <= 1'b0;
			exp_busy  <= 1'b0;
			head      <= '0;
			total     <= '0;
			lead      <= '0;
			for (int t = 0; t < `MPU_THREADS; t++) begin
				len_shadow[t] <= '0;
			end
			for (int a = 0; a < `MPU_DATA_DEPTH; a++) begin
				data_known[a] <= 1'b0;
			end
		end else begin
			if (stream_on) begin
				if (lead != 0) begin
					lead <= lead - 1'b1;
					if (lead == 1 && total == 0) begin
						stream_on <= 1'b0;
						exp_busy  <= 1'b0;
					end
				end else if (head != total) begin
					head <= head + 1'b1;
					if (head + 1'b1 == total) begin
						stream_on <= 1'b0;
						exp_busy  <= 1'b0;
					end
				end
			end
			if (host_req && !exp_busy) begin
				case (state)
					IDLE: begin
						case (mpu_opcode_e'(host_data[31:29]))
							OP_STOP:       state <= STOPPED;
							OP_RUN:        state <= RUN_ID;
							OP_STORE_PROG: state <= PROG_ID;
							OP_STORE_DATA: state <= ST_COUNT;
							OP_LOAD_DATA:  state <= LD_COUNT;
							default:       state <= IDLE;
						endcase
					end
					STOPPED: begin
						if (mpu_opcode_e'(host_data[31:29]) == OP_START) begin
							state <= IDLE;
						end
					end
					RUN_ID: begin
						for (int i = 0; i < `MPU_PROG_LEN; i++) begin
							exp_word[i]  <= prog_shadow[host_data[1:0]][i];
							exp_known[i] <= 1'b1;
						end
						total       <= 9'(len_shadow[host_data[1:0]]);
						head        <= '0;
						lead        <= 2'd2;
						stream_on   <= 1'b1;
						stream_load <= 1'b0;
						exp_busy    <= 1'b1;
						state       <= IDLE;
					end
					PROG_ID: begin
						thr   <= host_data[1:0];
						state <= PROG_COUNT;
					end
					PROG_COUNT: begin
						if (req_len == 0) begin
							state <= IDLE;
						end else begin
							len_shadow[thr] <= req_len;
							plen_q <= req_len;
							pidx   <= '0;
							state  <= PROG_WORDS;
						end
					end
					PROG_WORDS: begin
						prog_shadow[thr][pidx[3:0]] <= host_data;
						pidx <= pidx + 1'b1;
						if (pidx + 1'b1 == plen_q) begin
							state <= IDLE;
						end
					end
					ST_COUNT, LD_COUNT: begin
						cnt   <= host_data[8:0];
						state <= (state == ST_COUNT) ? ST_STRIDE : LD_STRIDE;
					end
					ST_STRIDE, LD_STRIDE: begin
						stride <= host_data[7:0];
						state  <= (state == ST_STRIDE) ? ST_BASE : LD_BASE;
					end
					ST_BASE: begin
						addr  <= host_data[7:0];
						left  <= cnt;
						state <= (cnt == 0) ? IDLE : ST_WORDS;
					end
					ST_WORDS: begin
						data_shadow[addr] <= host_data;
						data_known[addr]  <= 1'b1;
						addr  <= addr + stride;
						left  <= left - 1'b1;
						state <= (left == 1) ? IDLE : ST_WORDS;
					end
					LD_BASE: begin
						if (cnt != 0) begin
							for (int i = 0; i < 512; i++) begin
								rd_addr = host_data[7:0] + 8'(i) * stride;
								exp_word[i]  <= data_shadow[rd_addr];
								exp_known[i] <= data_known[rd_addr];
							end
							total       <= cnt;
							head        <= '0;
							lead        <= 2'd2;
							stream_on   <= 1'b1;
							stream_load <= 1'b1;
							exp_busy    <= 1'b1;
						end
						state <= IDLE;
					end
					default: state <= IDLE;
				endcase
			end
		end
	end

	// ############################################################
	// output checks.
	a_busy: assert property (@(posedge clock) disable iff (reset) busy == exp_busy)
		else begin
			note_failure("busy", 32'($sampled(busy)), 32'($sampled(exp_busy)));
			$error("busy differs from the expected level");
		end

	a_stopped: assert property (@(posedge clock) disable iff (reset)
			stopped == (state == STOPPED))
		else begin
			note_failure("stopped", 32'($sampled(stopped)),
				32'($sampled(state == STOPPED)));
			$error("stopped differs from the expected level");
		end

	a_rd_valid: assert property (@(posedge clock) disable iff (reset)
			rd_valid == exp_rd_valid)
		else begin
			note_failure("rd_valid", 32'($sampled(rd_valid)), 32'($sampled(exp_rd_valid)));
			$error("rd_valid out of step with the load stream");
		end

	a_rd_data: assert property (@(posedge clock) disable iff (reset)
			rd_valid && exp_rd_valid && exp_head_known |-> rd_data == exp_head)
		else begin
			note_failure("rd_data", $sampled(rd_data), $sampled(exp_head));
			$error("rd_data differs from the shadow memory");
		end

	a_instr_valid: assert property (@(posedge clock) disable iff (reset)
			instr_valid == exp_instr_valid)
		else begin
			note_failure("instr_valid", 32'($sampled(instr_valid)),
				32'($sampled(exp_instr_valid)));
			$error("instr_valid out of step with the program stream");
		end

	a_instr: assert property (@(posedge clock) disable iff (reset)
			instr_valid && exp_instr_valid |-> instr == exp_head)
		else begin
			note_failure("instr", $sampled(instr), $sampled(exp_head));
			$error("instr differs from the shadow program");
		end

endmodule

`default_nettype wire

// File: test/mpu_host_tb.sv
/* Testbench for the host command port: clock, reset, seeded command stimulus,
   timeout and the final verdict. */

`include "mpu_params.svh"

`default_nettype none

module mpu_host_tb
	import mpu_pkg::*;
;

	timeunit 1ns;
	timeprecision 1ps;

	// under 150 host words at 2 cycles each plus the streams stay far below this.
	localparam int MAX_CYCLES = 4000;

	logic      clock;
	logic      reset;
	logic      host_req;
	mpu_word_t host_data;
	logic      busy;
	logic      stopped;
	logic      instr_valid;
	mpu_word_t instr;
	logic      rd_valid;
	mpu_word_t rd_data;
	int        cycles;
	logic [7:0] ld_stride;
	logic [7:0] ld_base;

	mpu_host_top u_mpu_host_top (
		.clock       (clock),
		.reset       (reset),
		.host_req    (host_req),
		.host_data   (host_data),
		.busy        (busy),
		.stopped     (stopped),
		.instr_valid (instr_valid),
		.instr       (instr),
		.rd_valid    (rd_valid),
		.rd_data     (rd_data)
	);

	bind mpu_host_top mpu_host_chk u_mpu_host_chk (
		.clock       (clock),
		.reset       (reset),
		.host_req    (host_req),
		.host_data   (host_data),
		.busy        (busy),
		.stopped     (stopped),
		.instr_valid (instr_valid),
		.instr       (instr),
		.rd_valid    (rd_valid),
		.rd_data     (rd_data)
	);

	initial clock = 1'b0;
	always #20 clock = ~clock;

	task automatic end_with_failure();
		$display("TEST FAILED");
		$fatal(1, "run stopped after a failure");
	endtask

	// ############################################################
	// failure watch and timeout.
	always @(negedge clock) begin
		if (u_mpu_host_top.u_mpu_host_chk.fail_flag) begin
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time,
				u_mpu_host_top.u_mpu_host_chk.fail_name,
				u_mpu_host_top.u_mpu_host_chk.fail_got,
				u_mpu_host_top.u_mpu_host_chk.fail_exp);
			end_with_failure();
		end
	end

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			end_with_failure();
		end
	end

	// ############################################################
	// host word tasks.
	function automatic mpu_word_t make_cmd(input mpu_opcode_e op);
		return {op, 29'd0};
	endfunction

	task automatic drive_word(input mpu_word_t w);
		@(posedge clock);
		#2;
		host_req  = 1'b1;
		host_data = w;
		@(posedge clock);
		#2;
		host_req  = 1'b0;
	endtask

	task automatic wait_ready();
		while (busy) begin
			@(posedge clock);
			#2;
		end
	endtask

	task automatic store_data(input int count, input logic [7:0] stride,
			input logic [7:0] base);
		wait_ready();
		drive_word(make_cmd(OP_STORE_DATA));
		drive_word(mpu_word_t'(count));
		drive_word(mpu_word_t'(stride));
		drive_word(mpu_word_t'(base));
		for (int i = 0; i < count; i++) begin
			drive_word($urandom);
		end
	endtask

	task automatic load_data(input int count, input logic [7:0] stride,
			input logic [7:0] base);
		wait_ready();
		drive_word(make_cmd(OP_LOAD_DATA));
		drive_word(mpu_word_t'(count));
		drive_word(mpu_word_t'(stride));
		drive_word(mpu_word_t'(base));
	endtask

	task automatic store_prog(input int thread, input int len);
		wait_ready();
		drive_word(make_cmd(OP_STORE_PROG));
		drive_word(mpu_word_t'(thread));
		drive_word(mpu_word_t'(len));
		for (int i = 0; i < len; i++) begin
			drive_word($urandom);
		end
	endtask

	task automatic run_thread(input int thread);
		wait_ready();
		drive_word(make_cmd(OP_RUN));
		drive_word(mpu_word_t'(thread));
	endtask

	// ############################################################
	// stimulus.
	initial begin
		void'($urandom(32'h7124de55));
		cycles    = 0;
		reset     = 1'b1;
		host_req  = 1'b0;
		host_data = '0;
		repeat (16) @(posedge clock);
		#2;
		reset = 1'b0;
		repeat (4) @(posedge clock);

		// a thread that was never stored has length zero.
		run_thread(2);

		ld_stride = 8'(($urandom % 128) * 2 + 1);
		ld_base   = 8'($urandom);
		store_data(12, ld_stride, ld_base);
		load_data(12, ld_stride, ld_base);

		for (int t = 0; t < `MPU_THREADS; t++) begin
			store_prog(t, 1 + ($urandom % 16));
		end
		for (int t = 0; t < `MPU_THREADS; t++) begin
			run_thread(t);
		end

		// while stopped, RUN and LOAD_DATA words are dropped.
		wait_ready();
		drive_word(make_cmd(OP_STOP));
		drive_word(make_cmd(OP_RUN));
		drive_word(32'd1);
		drive_word(make_cmd(OP_LOAD_DATA));
		drive_word(32'd4);
		drive_word(mpu_word_t'(ld_stride));
		drive_word(mpu_word_t'(ld_base));
		drive_word(make_cmd(OP_START));
		run_thread(1);
		load_data(4, ld_stride, ld_base);

		// a store sent during a load stream must not reach the memory.
		load_data(12, ld_stride, ld_base);
		drive_word(make_cmd(OP_STORE_DATA));
		drive_word(32'd1);
		drive_word(mpu_word_t'(ld_stride));
		drive_word(mpu_word_t'(ld_base));
		drive_word($urandom);
		store_data(0, ld_stride, ld_base);
		wait_ready();
		drive_word({3'd7, 29'($urandom)});
		drive_word({3'd6, 29'($urandom)});
		load_data(12, ld_stride, ld_base);
		wait_ready();
		repeat (6) @(posedge clock);

		if (u_mpu_host_top.u_mpu_host_chk.fail_flag) begin
			end_with_failure();
		end else begin
			$display("TEST OK");
			$finish;
		end
	end

endmodule

`default_nettype wire
